/* Makefile */
TOP := fight_game_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f fight_game.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f fight_game.f -o fight_game_sim
	./obj_dir/fight_game_sim | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* fight_game.f */
+incdir+src
src/fight_game_pkg.sv
src/stun_onset_detect.sv
src/second_timer.sv
src/damage_resolver.sv
src/fight_sequencer.sv
src/menu_controller.sv
src/fight_game_top.sv
verification/fight_game_chk.sv
verification/fight_game_tb.sv

/* src/damage_resolver.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fight_game_config.svh"

module damage_resolver
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  fight_phase_e    fight_phase,
    input  fighter_status_t p1_status,
    input  fighter_status_t p2_status,
    input  onset_t          p1_onset,
    input  onset_t          p2_onset,
    output fighter_meters_t p1_meters,
    output fighter_meters_t p2_meters,
    output frame_t          p1_load_frame,
    output frame_t          p2_load_frame
);

    fighter_status_t status_a [2];
    onset_t          onset_a  [2];
    fighter_meters_t meters_q [2];
    frame_t          load_q   [2];
    logic            both_clear;

    assign status_a[0] = p1_status;
    assign status_a[1] = p2_status;
    assign onset_a[0]  = p1_onset;
    assign onset_a[1]  = p2_onset;

    assign both_clear = (p1_status.stun == ST_NOHIT) && (p2_status.stun == ST_NOHIT);

    // Fighter i is hit by fighter 1-i, each resolved on its own
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                meters_q[i] <= '{health: `METER_FULL, block: `METER_FULL};
                load_q[i]   <= '0;
            end
        end else if (fight_phase == PH_IDLE) begin
            for (int i = 0; i < 2; i++) begin
                meters_q[i] <= '{health: `METER_FULL, block: `METER_FULL}; // Refill for next match
                load_q[i]   <= '0;
            end
        end else if (fight_phase == PH_ACTIVE) begin
            if (both_clear) begin
                load_q[0] <= '0;
                load_q[1] <= '0;
            end
            for (int i = 0; i < 2; i++) begin
                if (onset_a[i].new_hit) begin
                    meters_q[i].health <= meters_q[i].health >> 1;
                    if (status_a[1-i].anim inside {AN_ATTACK_ACTIVE, AN_ATTACK_RECOVERY}) begin
                        load_q[i] <= status_a[1-i].frame_cnt + frame_t'(`HIT_ADVANCE);
                    end else if (status_a[1-i].anim inside {AN_DIR_ACTIVE, AN_DIR_RECOVERY}) begin
                        load_q[i] <= status_a[1-i].frame_cnt + frame_t'(`DIR_HIT_ADVANCE);
                    end
                end else if (onset_a[i].new_block) begin
                    meters_q[i].block <= meters_q[i].block >> 1;
                    if (status_a[1-i].anim == AN_ATTACK_ACTIVE) begin
                        load_q[i] <= status_a[1-i].frame_cnt + frame_t'(`BLOCK_ADVANCE);
                    end else if (status_a[1-i].anim == AN_DIR_ACTIVE) begin
                        load_q[i] <= status_a[1-i].frame_cnt + frame_t'(`DIR_BLOCK_ADVANCE);
                    end
                end
            end
        end
    end

    assign p1_meters     = meters_q[0];
    assign p2_meters     = meters_q[1];
    assign p1_load_frame = load_q[0];
    assign p2_load_frame = load_q[1];

endmodule

`default_nettype wire

/* src/fight_game_config.svh */
`ifndef FIGHT_GAME_CONFIG_SVH
`define FIGHT_GAME_CONFIG_SVH

// Game second from the 60 Hz clock
`define TICKS_PER_SECOND 60

`define COUNTDOWN_SECONDS 3
`define ROUND_END_SECOND 103     // Countdown plus a 99 s round and a short margin
`define END_HOLD_SECONDS 5

`define METER_FULL 3'b111

// Frames the victim skips ahead of the attacker on resume
`define HIT_ADVANCE 15
`define DIR_HIT_ADVANCE 14
`define BLOCK_ADVANCE 13
`define DIR_BLOCK_ADVANCE 12

`endif

/* src/fight_game_pkg.sv */
`default_nettype none

package fight_game_pkg;

    typedef logic [7:0] seconds_t;
    typedef logic [2:0] meter_t;      // Halves on each event, 7 3 1 0
    typedef logic [4:0] frame_t;
    typedef logic [6:0] seg_digit_t;  // Active low, bit 6 is segment g

    typedef enum logic [3:0] {
        AN_IDLE            = 4'd0,
        AN_LEFT            = 4'd1,
        AN_RIGHT           = 4'd2,
        AN_ATTACK_START    = 4'd3,
        AN_ATTACK_ACTIVE   = 4'd4,
        AN_ATTACK_RECOVERY = 4'd5,
        AN_DIR_START       = 4'd6,
        AN_DIR_ACTIVE      = 4'd7,
        AN_DIR_RECOVERY    = 4'd8,
        AN_STUN            = 4'd9
    } anim_state_e;

    typedef enum logic [1:0] {
        ST_NOHIT     = 2'd0,
        ST_HITSTUN   = 2'd1,
        ST_BLOCKSTUN = 2'd2
    } stun_e;

    typedef enum logic [2:0] {
        PH_IDLE     = 3'd0,
        PH_START    = 3'd1,  // Countdown
        PH_ACTIVE   = 3'd2,
        PH_END_P1   = 3'd3,
        PH_END_P2   = 3'd4,
        PH_END_DRAW = 3'd5
    } fight_phase_e;

    typedef enum logic {
        GS_MENU = 1'b0,
        GS_GAME = 1'b1
    } game_state_e;

    // Reported by the character logic of one fighter
    typedef struct packed {
        anim_state_e anim;
        stun_e       stun;
        frame_t      frame_cnt;
    } fighter_status_t;

    typedef struct packed {
        meter_t health;
        meter_t block;
    } fighter_meters_t;

    typedef struct packed {
        logic new_hit;
        logic new_block;
    } onset_t;

endpackage

`default_nettype wire

/* src/fight_game_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fight_game_top
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start_btn,
    input  logic            mode_switch,
    input  fighter_status_t p1_status,
    input  fighter_status_t p2_status,
    output frame_t          p1_load_frame,
    output frame_t          p2_load_frame,
    output fighter_meters_t p1_meters,
    output fighter_meters_t p2_meters,
    output meter_t          p1_health_led,
    output meter_t          p2_health_led,
    output fight_phase_e    fight_phase,
    output logic            input_active,
    output logic            game_active,
    output logic            menu_active,
    output logic            mode_selected,
    output seg_digit_t      hex0,
    output seg_digit_t      hex1,
    output seg_digit_t      hex2,
    output seg_digit_t      hex3,
    output seg_digit_t      hex4,
    output seg_digit_t      hex5
);

    onset_t   p1_onset;
    onset_t   p2_onset;
    seconds_t seconds;

    stun_onset_detect u_onset (
        .clk       (clk),
        .rst       (rst),
        .p1_status (p1_status),
        .p2_status (p2_status),
        .p1_onset  (p1_onset),
        .p2_onset  (p2_onset)
    );

    second_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .fight_phase (fight_phase),
        .seconds     (seconds)
    );

    damage_resolver u_damage (
        .clk           (clk),
        .rst           (rst),
        .fight_phase   (fight_phase),
        .p1_status     (p1_status),
        .p2_status     (p2_status),
        .p1_onset      (p1_onset),
        .p2_onset      (p2_onset),
        .p1_meters     (p1_meters),
        .p2_meters     (p2_meters),
        .p1_load_frame (p1_load_frame),
        .p2_load_frame (p2_load_frame)
    );

    fight_sequencer u_seq (
        .clk          (clk),
        .rst          (rst),
        .game_active  (game_active),
        .seconds      (seconds),
        .p1_meters    (p1_meters),
        .p2_meters    (p2_meters),
        .fight_phase  (fight_phase),
        .input_active (input_active)
    );

    menu_controller u_menu (
        .clk           (clk),
        .rst           (rst),
        .start_btn     (start_btn),
        .mode_switch   (mode_switch),
        .fight_phase   (fight_phase),
        .p1_meters     (p1_meters),
        .p2_meters     (p2_meters),
        .game_active   (game_active),
        .menu_active   (menu_active),
        .mode_selected (mode_selected),
        .p1_health_led (p1_health_led),
        .p2_health_led (p2_health_led),
        .hex0          (hex0),
        .hex1          (hex1),
        .hex2          (hex2),
        .hex3          (hex3),
        .hex4          (hex4),
        .hex5          (hex5)
    );

endmodule

`default_nettype wire

/* src/fight_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fight_game_config.svh"

module fight_sequencer
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            game_active,
    input  seconds_t        seconds,
    input  fighter_meters_t p1_meters,
    input  fighter_meters_t p2_meters,
    output fight_phase_e    fight_phase,
    output logic            input_active
);

    fight_phase_e phase_q;
    fight_phase_e phase_d;
    seconds_t     finish_q;
    logic         wait_release_q;  // Set after a match until the menu drops game_active
    logic         p1_ko;
    logic         p2_ko;
    logic         timeout;
    logic         hold_done;

    assign p1_ko     = (p1_meters.health == '0);
    assign p2_ko     = (p2_meters.health == '0);
    assign timeout   = (seconds == seconds_t'(`ROUND_END_SECOND));
    assign hold_done = (seconds >= seconds_t'(finish_q + seconds_t'(`END_HOLD_SECONDS)));

    always_comb begin
        phase_d = phase_q;
        case (phase_q)
            PH_IDLE: begin
                if (game_active && !wait_release_q) begin
                    phase_d = PH_START;
                end
            end
            PH_START: begin
                if (seconds == seconds_t'(`COUNTDOWN_SECONDS)) begin
                    phase_d = PH_ACTIVE;
                end
            end
            PH_ACTIVE: begin
                if ((p1_ko && p2_ko) || timeout) begin
                    phase_d = PH_END_DRAW;
                end else if (p1_ko) begin
                    phase_d = PH_END_P2;
                end else if (p2_ko) begin
                    phase_d = PH_END_P1;
                end
            end
            PH_END_P1, PH_END_P2, PH_END_DRAW: begin
                if (hold_done) begin
                    phase_d = PH_IDLE;
                end
            end
            default: phase_d = PH_IDLE;
        endcase
        if (!game_active) begin
            phase_d = PH_IDLE;   // Menu has taken over
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase_q        <= PH_IDLE;
            input_active   <= 1'b0;
            wait_release_q <= 1'b0;
        end else begin
            phase_q      <= phase_d;
            input_active <= (phase_d == PH_ACTIVE);
            if (!game_active) begin
                wait_release_q <= 1'b0;
            end else if (phase_d inside {PH_END_P1, PH_END_P2, PH_END_DRAW}) begin
                wait_release_q <= 1'b1;
            end
        end
    end

    // Tracks the clock while fighting, frozen once the match ends
    always_ff @(posedge clk) begin
        if (phase_q == PH_ACTIVE) begin
            finish_q <= seconds;
        end
    end

    assign fight_phase = phase_q;

endmodule

`default_nettype wire

/* src/menu_controller.sv */
`timescale 1ns/100ps
`default_nettype none

module menu_controller
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start_btn,
    input  logic            mode_switch,
    input  fight_phase_e    fight_phase,
    input  fighter_meters_t p1_meters,
    input  fighter_meters_t p2_meters,
    output logic            game_active,
    output logic            menu_active,
    output logic            mode_selected,
    output meter_t          p1_health_led,
    output meter_t          p2_health_led,
    output seg_digit_t      hex0,
    output seg_digit_t      hex1,
    output seg_digit_t      hex2,
    output seg_digit_t      hex3,
    output seg_digit_t      hex4,
    output seg_digit_t      hex5
);

    // Element 5 drives hex5, the leftmost digit
    localparam seg_digit_t [5:0] SEG_FIGHT =
        {7'b0001110, 7'b1001111, 7'b0000010, 7'b0001001, 7'b1111000, 7'b1001110};
    localparam seg_digit_t [5:0] SEG_1P =
        {7'b1111111, 7'b1111111, 7'b1111001, 7'b0001100, 7'b1111111, 7'b1111111};
    localparam seg_digit_t [5:0] SEG_2P =
        {7'b1111111, 7'b1111111, 7'b0100100, 7'b0001100, 7'b1111111, 7'b1111111};

    game_state_e      game_state_q;
    seg_digit_t [5:0] seg_q;
    logic             match_over_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_state_q  <= GS_MENU;
            game_active   <= 1'b0;
            menu_active   <= 1'b1;
            mode_selected <= 1'b0;
            match_over_q  <= 1'b0;
            seg_q         <= SEG_2P;
        end else if (game_state_q == GS_MENU) begin
            mode_selected <= mode_switch;
            seg_q         <= mode_switch ? SEG_1P : SEG_2P;
            if (start_btn) begin
                game_state_q <= GS_GAME;
                game_active  <= 1'b1;
                menu_active  <= 1'b0;
                seg_q        <= SEG_FIGHT;
            end
        end else begin
            if (fight_phase inside {PH_END_P1, PH_END_P2, PH_END_DRAW}) begin
                match_over_q <= 1'b1;
            end
            if (match_over_q && (fight_phase == PH_IDLE)) begin
                game_state_q <= GS_MENU;
                game_active  <= 1'b0;   // Same clock, so the sequencer never restarts
                menu_active  <= 1'b1;
                match_over_q <= 1'b0;
                seg_q        <= mode_switch ? SEG_1P : SEG_2P;
            end
        end
    end

    assign p1_health_led = (game_state_q == GS_GAME) ? p1_meters.health : '0;
    assign p2_health_led = (game_state_q == GS_GAME) ? p2_meters.health : '0;

    assign hex0 = seg_q[0];
    assign hex1 = seg_q[1];
    assign hex2 = seg_q[2];
    assign hex3 = seg_q[3];
    assign hex4 = seg_q[4];
    assign hex5 = seg_q[5];

endmodule

`default_nettype wire

/* src/second_timer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fight_game_config.svh"

module second_timer
    import fight_game_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  fight_phase_e fight_phase,
    output seconds_t     seconds
);

    localparam int PRESCALE_W = $clog2(`TICKS_PER_SECOND);
    localparam logic [PRESCALE_W-1:0] PRESCALE_LAST = PRESCALE_W'(`TICKS_PER_SECOND - 1);

    logic [PRESCALE_W-1:0] prescale_q;
    seconds_t              seconds_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prescale_q <= '0;
            seconds_q  <= '0;
        end else if (fight_phase == PH_IDLE) begin
            prescale_q <= '0;   // Restart from zero for every match
            seconds_q  <= '0;
        end else if (prescale_q == PRESCALE_LAST) begin
            prescale_q <= '0;
            seconds_q  <= seconds_q + 8'd1;
        end else begin
            prescale_q <= prescale_q + 1'b1;
        end
    end

    assign seconds = seconds_q;

endmodule

`default_nettype wire

/* src/stun_onset_detect.sv */
`timescale 1ns/100ps
`default_nettype none

module stun_onset_detect
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  fighter_status_t p1_status,
    input  fighter_status_t p2_status,
    output onset_t          p1_onset,
    output onset_t          p2_onset
);

    stun_e  stun_a    [2];
    stun_e  prev_stun [2];
    onset_t onset_q   [2];

    assign stun_a[0] = p1_status.stun;
    assign stun_a[1] = p2_status.stun;

    // An onset is a stun sample right after a NOHIT sample
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2; i++) begin
                prev_stun[i] <= ST_NOHIT;
                onset_q[i]   <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                prev_stun[i]         <= stun_a[i];
                onset_q[i].new_hit   <= (prev_stun[i] == ST_NOHIT) && (stun_a[i] == ST_HITSTUN);
                onset_q[i].new_block <= (prev_stun[i] == ST_NOHIT) && (stun_a[i] == ST_BLOCKSTUN);
            end
        end
    end

    assign p1_onset = onset_q[0];
    assign p2_onset = onset_q[1];

endmodule

`default_nettype wire

/* verification/fight_game_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module fight_game_chk
    import fight_game_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            input_active,
    input  logic            game_active,
    input  logic            menu_active,
    input  fight_phase_e    fight_phase,
    input  meter_t          p1_health_led,
    input  meter_t          p2_health_led,
    input  fighter_meters_t p1_meters,
    input  fighter_meters_t p2_meters
);

    // Sequencer and menu must agree that a match is running
    a_input_only_active: assert property (@(posedge clk) disable iff (rst)
        input_active |-> ((fight_phase == PH_ACTIVE) && game_active && !menu_active))
        else $error("input_active high outside a running fight");

    a_leds_dark_in_menu: assert property (@(posedge clk) disable iff (rst)
        menu_active |-> ((p1_health_led == '0) && (p2_health_led == '0) &&
                         (fight_phase == PH_IDLE)))
        else $error("health LEDs lit or fight running while the menu is shown");

    // Refill is only allowed after an IDLE cycle
    a_p1_health_no_rise: assert property (@(posedge clk) disable iff (rst)
        ($past(fight_phase) != PH_IDLE) |-> (p1_meters.health <= $past(p1_meters.health)))
        else $error("p1 health rose outside IDLE");

    a_p2_health_no_rise: assert property (@(posedge clk) disable iff (rst)
        ($past(fight_phase) != PH_IDLE) |-> (p2_meters.health <= $past(p2_meters.health)))
        else $error("p2 health rose outside IDLE");

endmodule

bind fight_game_top fight_game_chk u_chk (
    .clk           (clk),
    .rst           (rst),
    .input_active  (input_active),
    .game_active   (game_active),
    .menu_active   (menu_active),
    .fight_phase   (fight_phase),
    .p1_health_led (p1_health_led),
    .p2_health_led (p2_health_led),
    .p1_meters     (p1_meters),
    .p2_meters     (p2_meters)
);

`default_nettype wire

/* verification/fight_game_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "fight_game_config.svh"

module fight_game_tb
    import fight_game_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int TPS        = `TICKS_PER_SECOND;
    localparam int WATCHDOG_CYCLES =
        (`ROUND_END_SECOND + `END_HOLD_SECONDS + 10) * `TICKS_PER_SECOND * 3;

    // Active low, bit 0 is segment a
    localparam seg_digit_t SEG_BLANK = 7'b1111111;
    localparam seg_digit_t SEG_ONE   = 7'b1111001;
    localparam seg_digit_t SEG_TWO   = 7'b0100100;
    localparam seg_digit_t SEG_P     = 7'b0001100;
    localparam seg_digit_t SEG_F     = 7'b0001110;
    localparam seg_digit_t SEG_I     = 7'b1001111;
    localparam seg_digit_t SEG_G     = 7'b0000010;
    localparam seg_digit_t SEG_H     = 7'b0001001;
    localparam seg_digit_t SEG_T_L   = 7'b1111000;   // T spans hex1 and hex0
    localparam seg_digit_t SEG_T_R   = 7'b1001110;

    localparam logic [41:0] MSG_1P = {SEG_BLANK, SEG_BLANK, SEG_ONE, SEG_P, SEG_BLANK, SEG_BLANK};
    localparam logic [41:0] MSG_2P = {SEG_BLANK, SEG_BLANK, SEG_TWO, SEG_P, SEG_BLANK, SEG_BLANK};
    localparam logic [41:0] MSG_FIGHT = {SEG_F, SEG_I, SEG_G, SEG_H, SEG_T_L, SEG_T_R};

    localparam fighter_status_t IDLE_STATUS = '{anim: AN_IDLE, stun: ST_NOHIT, frame_cnt: 5'd0};

    typedef struct packed {
        logic        mode;
        logic [41:0] digits;
    } menu_row_t;

    typedef struct packed {
        logic        p2_attacks;   // Victim is p1 when set
        anim_state_e anim;
        stun_e       stun;
        meter_t      exp_meter;
        logic        adv_used;
        frame_t      adv;
    } strike_row_t;

    logic            clk;
    logic            rst;
    logic            start_btn;
    logic            mode_switch;
    fighter_status_t p1_status;
    fighter_status_t p2_status;
    frame_t          p1_load_frame;
    frame_t          p2_load_frame;
    fighter_meters_t p1_meters;
    fighter_meters_t p2_meters;
    meter_t          p1_health_led;
    meter_t          p2_health_led;
    fight_phase_e    fight_phase;
    logic            input_active;
    logic            game_active;
    logic            menu_active;
    logic            mode_selected;
    seg_digit_t      hex0;
    seg_digit_t      hex1;
    seg_digit_t      hex2;
    seg_digit_t      hex3;
    seg_digit_t      hex4;
    seg_digit_t      hex5;
    logic [41:0]     hex_all;

    menu_row_t   menu_tab   [4];
    strike_row_t strike_tab [7];
    meter_t      exp_health [2];
    meter_t      exp_block  [2];
    integer      seed;
    int          rnd;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;

    assign hex_all = {hex5, hex4, hex3, hex2, hex1, hex0};

    fight_game_top uut (
        .clk           (clk),
        .rst           (rst),
        .start_btn     (start_btn),
        .mode_switch   (mode_switch),
        .p1_status     (p1_status),
        .p2_status     (p2_status),
        .p1_load_frame (p1_load_frame),
        .p2_load_frame (p2_load_frame),
        .p1_meters     (p1_meters),
        .p2_meters     (p2_meters),
        .p1_health_led (p1_health_led),
        .p2_health_led (p2_health_led),
        .fight_phase   (fight_phase),
        .input_active  (input_active),
        .game_active   (game_active),
        .menu_active   (menu_active),
        .mode_selected (mode_selected),
        .hex0          (hex0),
        .hex1          (hex1),
        .hex2          (hex2),
        .hex3          (hex3),
        .hex4          (hex4),
        .hex5          (hex5)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d clock cycles, run stopped", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    task automatic load_tables();
        menu_tab[0] = '{1'b1, MSG_1P};
        menu_tab[1] = '{1'b0, MSG_2P};
        menu_tab[2] = '{1'b1, MSG_1P};
        menu_tab[3] = '{1'b0, MSG_2P};
        // p2_attacks, attacker anim, victim stun, meter after, advance used, advance
        strike_tab[0] = '{1'b1, AN_ATTACK_ACTIVE, ST_HITSTUN, 3'd3, 1'b1, frame_t'(`HIT_ADVANCE)};
        strike_tab[1] = '{1'b1, AN_DIR_RECOVERY, ST_HITSTUN, 3'd1, 1'b1,
                          frame_t'(`DIR_HIT_ADVANCE)};
        strike_tab[2] = '{1'b0, AN_ATTACK_ACTIVE, ST_BLOCKSTUN, 3'd3, 1'b1,
                          frame_t'(`BLOCK_ADVANCE)};
        strike_tab[3] = '{1'b0, AN_DIR_ACTIVE, ST_BLOCKSTUN, 3'd1, 1'b1,
                          frame_t'(`DIR_BLOCK_ADVANCE)};
        strike_tab[4] = '{1'b1, AN_ATTACK_RECOVERY, ST_BLOCKSTUN, 3'd3, 1'b0, 5'd0};
        strike_tab[5] = '{1'b1, AN_DIR_ACTIVE, ST_BLOCKSTUN, 3'd1, 1'b1,
                          frame_t'(`DIR_BLOCK_ADVANCE)};
        strike_tab[6] = '{1'b0, AN_ATTACK_ACTIVE, ST_BLOCKSTUN, 3'd0, 1'b1,
                          frame_t'(`BLOCK_ADVANCE)};
    endtask

    task automatic mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic problem(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        test_errors++;
    endtask

    task automatic close_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%-10s ok", name);
        end else begin
            $display("%-10s FAIL, %0d error(s)", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic check_digits(input logic [41:0] exp, input string what);
        if (hex_all !== exp) begin
            mismatch($sformatf("%s display %h, expected %h", what, hex_all, exp));
        end
    endtask

    task automatic drive_status(input fighter_status_t s1, input fighter_status_t s2);
        @(posedge clk);
        p1_status <= s1;
        p2_status <= s2;
    endtask

    task automatic press_start();
        @(posedge clk);
        start_btn <= 1'b1;
        @(posedge clk);
        start_btn <= 1'b0;
    endtask

    // Waits for the menu after an END phase, checks the hold time and the menu outputs
    task automatic check_return_to_menu(input string what);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!menu_active && cycles < (`END_HOLD_SECONDS + 1) * TPS + 8);
        if (!menu_active) begin
            problem($sformatf("menu did not come back after the %s", what));
        end else begin
            if (cycles < (`END_HOLD_SECONDS - 1) * TPS - 4) begin
                mismatch($sformatf("menu back after only %0d cycles", cycles));
            end
            if (p1_health_led !== '0 || p2_health_led !== '0) begin
                mismatch("health LEDs lit in the menu");
            end
            if (fight_phase !== PH_IDLE || game_active !== 1'b0) begin
                mismatch("fight not stopped on return to the menu");
            end
            check_digits(MSG_2P, what);
        end
    endtask

    task automatic run_menu_test();
        @(negedge clk);
        check_digits(MSG_2P, "reset");
        if (mode_selected !== 1'b0 || game_active !== 1'b0) begin
            mismatch("reset state of mode_selected or game_active wrong");
        end
        for (int i = 0; i < 4; i++) begin
            @(posedge clk);
            mode_switch <= menu_tab[i].mode;
            repeat (2) @(posedge clk);
            @(negedge clk);
            check_digits(menu_tab[i].digits, $sformatf("menu row %0d", i));
            if (mode_selected !== menu_tab[i].mode) begin
                mismatch($sformatf("menu row %0d mode_selected %b", i, mode_selected));
            end
            if (p1_health_led !== '0 || p2_health_led !== '0 || input_active !== 1'b0) begin
                mismatch($sformatf("menu row %0d LEDs or input_active not zero", i));
            end
        end
        close_test("menu");
    endtask

    task automatic run_countdown_test();
        int cycles;
        press_start();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!input_active && cycles < `COUNTDOWN_SECONDS * TPS + 4);
        if (!input_active) begin
            problem("input_active never rose after the countdown");
        end else if (cycles < (`COUNTDOWN_SECONDS - 1) * TPS) begin
            mismatch($sformatf("input_active rose after only %0d cycles", cycles));
        end
        check_digits(MSG_FIGHT, "countdown");
        if (game_active !== 1'b1 || menu_active !== 1'b0) begin
            mismatch("game_active or menu_active wrong during the match");
        end
        close_test("countdown");
    endtask

    task automatic run_strike_test(input stun_e kind, input string name);
        fighter_status_t atk;
        fighter_status_t vic;
        fighter_meters_t got;
        meter_t          led;
        frame_t          frame;
        frame_t          exp_load;
        frame_t          got_load;
        int              v;
        for (int i = 0; i < 7; i++) begin
            if (strike_tab[i].stun == kind) begin
                rnd = $random(seed);
                frame = rnd[4:0];
                v = strike_tab[i].p2_attacks ? 0 : 1;
                atk = '{anim: strike_tab[i].anim, stun: ST_NOHIT, frame_cnt: frame};
                vic = '{anim: AN_STUN, stun: kind, frame_cnt: 5'd0};
                if (v == 0) begin
                    drive_status(vic, atk);
                end else begin
                    drive_status(atk, vic);
                end
                repeat (3) @(posedge clk);   // Onset, then meter update
                @(negedge clk);
                exp_load = strike_tab[i].adv_used ? frame + strike_tab[i].adv : 5'd0;
                if (kind == ST_HITSTUN) begin
                    exp_health[v] = strike_tab[i].exp_meter;
                end else begin
                    exp_block[v] = strike_tab[i].exp_meter;
                end
                for (int f = 0; f < 2; f++) begin
                    got = (f == 0) ? p1_meters : p2_meters;
                    led = (f == 0) ? p1_health_led : p2_health_led;
                    if (got.health !== exp_health[f] || got.block !== exp_block[f]) begin
                        mismatch($sformatf("row %0d p%0d meters %h, expected %h%h",
                                           i, f + 1, got, exp_health[f], exp_block[f]));
                    end
                    if (led !== exp_health[f]) begin
                        mismatch($sformatf("row %0d p%0d health LEDs %0d, expected %0d",
                                           i, f + 1, led, exp_health[f]));
                    end
                end
                got_load = (v == 0) ? p1_load_frame : p2_load_frame;
                if (got_load !== exp_load) begin
                    mismatch($sformatf("row %0d load frame %0d, expected %0d",
                                       i, got_load, exp_load));
                end
                drive_status(IDLE_STATUS, IDLE_STATUS);
                repeat (2) @(posedge clk);
                @(negedge clk);
                if (p1_load_frame !== '0 || p2_load_frame !== '0) begin
                    mismatch($sformatf("row %0d load frames not cleared", i));
                end
            end
        end
        close_test(name);
    endtask

    task automatic run_knockout_test();
        fighter_status_t atk;
        fighter_status_t vic;
        atk = '{anim: AN_ATTACK_ACTIVE, stun: ST_NOHIT, frame_cnt: 5'd3};
        vic = '{anim: AN_STUN, stun: ST_HITSTUN, frame_cnt: 5'd0};
        for (int n = 0; n < 3; n++) begin
            drive_status(atk, vic);
            repeat (3) @(posedge clk);
            drive_status(IDLE_STATUS, IDLE_STATUS);
            repeat (2) @(posedge clk);
        end
        @(negedge clk);
        if (fight_phase !== PH_END_P1) begin
            mismatch($sformatf("phase %0d after the knockout, expected END_P1", fight_phase));
        end
        if (input_active !== 1'b0) begin
            mismatch("input_active still high after the knockout");
        end
        if (p2_meters.health !== 3'd0 || p1_meters.health !== exp_health[0]) begin
            mismatch("health values wrong after the knockout");
        end
        check_return_to_menu("knockout");
        close_test("knockout");
    endtask

    task automatic run_time_limit_test();
        int cycles;
        for (int f = 0; f < 2; f++) begin
            exp_health[f] = `METER_FULL;   // Refilled in IDLE
            exp_block[f]  = `METER_FULL;
        end
        press_start();
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!(fight_phase inside {PH_END_P1, PH_END_P2, PH_END_DRAW}) &&
                   cycles < (`ROUND_END_SECOND + 1) * TPS);
        if (fight_phase !== PH_END_DRAW) begin
            mismatch($sformatf("phase %0d at the time limit, expected END_DRAW", fight_phase));
        end else if (cycles < `ROUND_END_SECOND * TPS || cycles > `ROUND_END_SECOND * TPS + 8) begin
            mismatch($sformatf("time limit reached after %0d cycles", cycles));
        end
        if (p1_meters !== {exp_health[0], exp_block[0]} ||
            p2_meters !== {exp_health[1], exp_block[1]}) begin
            mismatch("meters not full in a match without hits");
        end
        check_return_to_menu("time limit");
        close_test("timelimit");
    endtask

    initial begin
        seed         = 32'hbb3b;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_tables();
        for (int f = 0; f < 2; f++) begin
            exp_health[f] = `METER_FULL;
            exp_block[f]  = `METER_FULL;
        end
        rst         = 1'b1;
        start_btn   = 1'b0;
        mode_switch = 1'b0;
        p1_status   = IDLE_STATUS;
        p2_status   = IDLE_STATUS;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        run_menu_test();
        run_countdown_test();
        run_strike_test(ST_HITSTUN, "hits");
        run_strike_test(ST_BLOCKSTUN, "blocks");
        run_knockout_test();
        run_time_limit_test();

        $display("Tests run %0d, with errors %0d, total errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
